/* hw/ddc_params.svh */
// ddc parameters
// widths and address step shared by the direct-download channel
// and its packages

`ifndef DDC_PARAMS_SVH
`define DDC_PARAMS_SVH

// ====================
// data path widths
// ====================
// data register and wbbr width
`define DDC_DATA_WIDTH 64
// physical address bits passed to wbbr
`define DDC_PA_WIDTH 40

// byte step between consecutive doubleword stores
`define DDC_ADDR_STEP 8

`endif

/* hw/dbg_reg_pkg.sv */
// debug register package
// types for the register-write side of the download channel:
// which register is written, and the write itself

`include "ddc_params.svh"

package dbg_reg_pkg;

  // ====================
  // register select
  // ====================
  // daddr holds the target address, ddata the doubleword to store
  typedef enum logic {
    sel_daddr = 1'b0,
    sel_ddata = 1'b1
  } dr_sel_t;

  // ====================
  // register write
  // ====================
  // one transport write, held stable while dr_req is high
  typedef struct packed {
    dr_sel_t                    sel;
    logic [`DDC_DATA_WIDTH-1:0] wdata;
  } dr_write_t;

endpackage

/* hw/ddc_inst_pkg.sv */
// instruction injection package
// packet sent to the core, the opcodes of the download sequence
// and the controller states

`include "ddc_params.svh"

package ddc_inst_pkg;

  // ====================
  // injection packet
  // ====================
  // instr goes to the core's ir, wbbr feeds the mv source
  // ffy set for instructions that read wbbr
  typedef struct packed {
    logic [31:0]                instr;
    logic [`DDC_DATA_WIDTH-1:0] wbbr;
    logic                       ffy;
  } inject_t;

  // ====================
  // opcodes
  // ====================
  // mv x1, x1
  localparam logic [31:0] inst_mv_x1    = 32'h00008093;
  // mv x2, x2
  localparam logic [31:0] inst_mv_x2    = 32'h00010113;
  // sd x2, 0(x1)
  localparam logic [31:0] inst_sd_x2_x1 = 32'h0020b023;

  // sequence states, st_wait covers start to done
  typedef enum logic [2:0] {
    st_idle, st_addr, st_data, st_store, st_wait
  } ddc_state_t;

endpackage

/* hw/ddc_dr_port.sv */
// debug register port
// four-phase slave on the transport side. each accepted write
// gives one update pulse and a held copy of the write. no new
// write is taken while a download is in progress

`timescale 1ns/1ps

module ddc_dr_port (
  input  logic                   cpuclk,
  input  logic                   reset,
  input  logic                   dr_req,
  input  dbg_reg_pkg::dr_write_t dr_wr,
  input  logic                   busy,
  output logic                   dr_ack,
  output logic                   update_en,
  output dbg_reg_pkg::dr_write_t wr
);

  // two states, ack low or ack high
  typedef enum logic {
    port_idle,
    port_ack
  } port_state_t;

  port_state_t state;

  // ====================
  // handshake
  // ====================
  always_ff @(posedge cpuclk)
  begin
    if (reset)
    begin
      state     <= port_idle;
      update_en <= 1'b0;
    end
    else
    begin
      // single cycle pulse
      update_en <= 1'b0;
      case (state)
        port_idle:
        begin
          // back-pressure, hold ack low until the download ends
          if (dr_req && !busy)
          begin
            state     <= port_ack;
            update_en <= 1'b1;
          end
        end
        port_ack:
        begin
          // wait for transport to drop req
          if (!dr_req)
            state <= port_idle;
        end
        default: state <= port_idle;
      endcase
    end
  end

  // capture the write as it is accepted
  always_ff @(posedge cpuclk)
  begin
    if ((state == port_idle) && dr_req && !busy)
      wr <= dr_wr;
  end

  assign dr_ack = (state == port_ack);

endmodule

/* hw/ddc_ctrl.sv */
// download controller
// sequences the three injections of one data write:
// address move, data move, store. bumps the address after
// the store and holds busy for the whole sequence

`timescale 1ns/1ps

module ddc_ctrl (
  input  logic                 cpuclk,
  input  logic                 reset,
  input  logic                 update_en,
  input  dbg_reg_pkg::dr_sel_t wr_sel,
  input  logic                 done,
  output logic                 busy,
  output logic                 start,
  output logic                 addr_sel,
  output logic                 data_sel,
  output logic                 addr_gen
);

  import dbg_reg_pkg::*;
  import ddc_inst_pkg::*;

  ddc_state_t state;
  // phase in flight, kept through st_wait
  ddc_state_t phase;

  // ====================
  // sequence fsm
  // ====================
  always_ff @(posedge cpuclk)
  begin
    if (reset)
    begin
      state    <= st_idle;
      phase    <= st_idle;
      busy     <= 1'b0;
      start    <= 1'b0;
      addr_gen <= 1'b0;
    end
    else
    begin
      // pulses
      start    <= 1'b0;
      addr_gen <= 1'b0;
      case (state)
        st_idle:
        begin
          // only a data write kicks off a download
          if (update_en && (wr_sel == sel_ddata))
          begin
            state <= st_addr;
            busy  <= 1'b1;
          end
        end
        st_addr, st_data, st_store:
        begin
          // one start per phase
          phase <= state;
          start <= 1'b1;
          state <= st_wait;
        end
        st_wait:
        begin
          if (done)
          begin
            case (phase)
              st_addr: state <= st_data;
              st_data: state <= st_store;
              default:
              begin
                // store retired, step to next doubleword
                state    <= st_idle;
                busy     <= 1'b0;
                addr_gen <= 1'b1;
              end
            endcase
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // phase decode for the datapath muxes
  assign addr_sel = (phase == st_addr);
  assign data_sel = (phase == st_data);

endmodule

/* hw/ddc_dp.sv */
// download datapath
// daddr and ddata registers, the address step after a store,
// and the mux that builds the injection packet for each phase

`timescale 1ns/1ps
`include "ddc_params.svh"

module ddc_dp (
  input  logic                   cpuclk,
  input  logic                   update_en,
  input  dbg_reg_pkg::dr_write_t wr,
  input  logic                   addr_sel,
  input  logic                   data_sel,
  input  logic                   addr_gen,
  output ddc_inst_pkg::inject_t  pkt
);

  import dbg_reg_pkg::*;
  import ddc_inst_pkg::*;

  logic [`DDC_DATA_WIDTH-1:0] daddr_q;
  logic [`DDC_DATA_WIDTH-1:0] ddata_q;
  logic [`DDC_DATA_WIDTH-1:0] wbbr;
  logic [31:0]                instr;

  // ====================
  // daddr and ddata
  // ====================
  // data register, loaded by a ddata write
  always_ff @(posedge cpuclk)
  begin
    if (update_en && (wr.sel == sel_ddata))
      ddata_q <= wr.wdata;
  end

  // address register, loaded by a daddr write
  // steps one doubleword after each store
  always_ff @(posedge cpuclk)
  begin
    if (update_en && (wr.sel == sel_daddr))
      daddr_q <= wr.wdata;
    else if (addr_gen)
      daddr_q <= daddr_q + `DDC_DATA_WIDTH'(`DDC_ADDR_STEP);
  end

  // ====================
  // packet build
  // ====================
  // address cut to physical width, upper bits zero
  assign wbbr = addr_sel
    ? {{(`DDC_DATA_WIDTH-`DDC_PA_WIDTH){1'b0}}, daddr_q[`DDC_PA_WIDTH-1:0]}
    : ddata_q;

  // mv x1 for address, mv x2 for data, otherwise the store
  assign instr = addr_sel ? inst_mv_x1 :
                 data_sel ? inst_mv_x2 : inst_sd_x2_x1;

  assign pkt.instr = instr;
  assign pkt.wbbr  = wbbr;
  // both moves read wbbr
  assign pkt.ffy   = addr_sel || data_sel;

endmodule

/* hw/ddc_inject_port.sv */
// injection port
// four-phase master toward the core. latches the packet at start
// and keeps it stable until the core has dropped ack, then
// reports done for one cycle

`timescale 1ns/1ps

module ddc_inject_port (
  input  logic                  cpuclk,
  input  logic                  reset,
  input  logic                  start,
  input  ddc_inst_pkg::inject_t pkt,
  input  logic                  inj_ack,
  output logic                  inj_req,
  output ddc_inst_pkg::inject_t inj,
  output logic                  done
);

  // idle, request out, released and waiting for ack low
  typedef enum logic [1:0] {
    ip_idle,
    ip_request,
    ip_release
  } inj_state_t;

  inj_state_t state;

  // ====================
  // handshake fsm
  // ====================
  always_ff @(posedge cpuclk)
  begin
    if (reset)
    begin
      state <= ip_idle;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        ip_idle:
          if (start)
            state <= ip_request;
        ip_request:
          // core took it, release req
          if (inj_ack)
            state <= ip_release;
        ip_release:
        begin
          // four-phase cycle closed
          if (!inj_ack)
          begin
            state <= ip_idle;
            done  <= 1'b1;
          end
        end
        default: state <= ip_idle;
      endcase
    end
  end

  // packet held from req rise through ack fall
  always_ff @(posedge cpuclk)
  begin
    if ((state == ip_idle) && start)
      inj <= pkt;
  end

  assign inj_req = (state == ip_request);

endmodule

/* hw/ddc_top.sv */
// debug direct-download channel
// register writes from the debug transport become store sequences
// injected into the core, one doubleword per data write

`timescale 1ns/1ps

module ddc_top (
  input  logic                   cpuclk,
  input  logic                   reset,
  input  logic                   dr_req,
  input  dbg_reg_pkg::dr_write_t dr_wr,
  output logic                   dr_ack,
  output logic                   inj_req,
  output ddc_inst_pkg::inject_t  inj,
  input  logic                   inj_ack
);

  import dbg_reg_pkg::*;
  import ddc_inst_pkg::*;

  // ====================
  // internal wires
  // ====================
  logic      update_en;
  dr_write_t wr;
  logic      busy;
  logic      start;
  logic      done;
  logic      addr_sel;
  logic      data_sel;
  logic      addr_gen;
  inject_t   pkt;

  // input side
  ddc_dr_port dr_port_i (
    .cpuclk    (cpuclk),
    .reset     (reset),
    .dr_req    (dr_req),
    .dr_wr     (dr_wr),
    .busy      (busy),
    .dr_ack    (dr_ack),
    .update_en (update_en),
    .wr        (wr)
  );

  // sequencing
  ddc_ctrl ctrl_i (
    .cpuclk    (cpuclk),
    .reset     (reset),
    .update_en (update_en),
    .wr_sel    (wr.sel),
    .done      (done),
    .busy      (busy),
    .start     (start),
    .addr_sel  (addr_sel),
    .data_sel  (data_sel),
    .addr_gen  (addr_gen)
  );

  // registers and packet mux
  ddc_dp dp_i (
    .cpuclk    (cpuclk),
    .update_en (update_en),
    .wr        (wr),
    .addr_sel  (addr_sel),
    .data_sel  (data_sel),
    .addr_gen  (addr_gen),
    .pkt       (pkt)
  );

  // output side
  ddc_inject_port inject_port_i (
    .cpuclk  (cpuclk),
    .reset   (reset),
    .start   (start),
    .pkt     (pkt),
    .inj_ack (inj_ack),
    .inj_req (inj_req),
    .inj     (inj),
    .done    (done)
  );

endmodule

/* bench/ddc_tb.sv */
// direct-download channel testbench
// applies a table of register writes as four-phase transfers,
// plays the core on the injection port with a random ack delay
// and checks every packet against a reference model

`timescale 1ns/1ps
`include "ddc_params.svh"

module ddc_tb;

  import dbg_reg_pkg::*;
  import ddc_inst_pkg::*;

  localparam int          tbl_len        = 13;
  localparam int          timeout_cycles = tbl_len * 40 + 100;
  localparam logic [31:0] seed           = 32'hae46cf1d;
  // keeps the physical address bits only
  localparam logic [`DDC_DATA_WIDTH-1:0] pa_mask =
    {{(`DDC_DATA_WIDTH-`DDC_PA_WIDTH){1'b0}}, {`DDC_PA_WIDTH{1'b1}}};

  // ====================
  // stimulus table
  // ====================
  // register select per write
  localparam dr_sel_t tbl_sel [tbl_len] = '{
    sel_daddr, sel_ddata, sel_ddata, sel_ddata,
    sel_daddr, sel_ddata, sel_ddata,
    sel_daddr, sel_ddata, sel_ddata,
    sel_daddr, sel_daddr, sel_ddata
  };
  // write data, some addresses with bits above 39 set
  localparam logic [`DDC_DATA_WIDTH-1:0] tbl_wdata [tbl_len] = '{
    64'h0000_0000_8000_0000,
    64'h1111_2222_3333_4444,
    64'hdead_beef_0bad_f00d,
    64'h0123_4567_89ab_cdef,
    64'hfff0_00ab_cdef_0ff8,
    64'h5555_aaaa_5555_aaaa,
    64'h8000_0000_0000_0001,
    64'hffff_ffff_ffff_fff8,
    64'hcafe_f00d_1234_5678,
    64'h0f0f_0f0f_f0f0_f0f0,
    64'h0000_0000_0000_1000,
    64'h0000_0000_0000_2000,
    64'h7777_6666_5555_4444
  };
  // expected wbbr of mv x1 on data rows, zero on address rows
  localparam logic [`DDC_DATA_WIDTH-1:0] tbl_exp_pa [tbl_len] = '{
    64'h0,
    64'h0000_0000_8000_0000,
    64'h0000_0000_8000_0008,
    64'h0000_0000_8000_0010,
    64'h0,
    64'h0000_00ab_cdef_0ff8,
    64'h0000_00ab_cdef_1000,
    64'h0,
    64'h0000_00ff_ffff_fff8,
    // address wrapped past the top
    64'h0000_0000_0000_0000,
    64'h0,
    64'h0,
    64'h0000_0000_0000_2000
  };

  logic      cpuclk;
  logic      reset;
  logic      dr_req;
  dr_write_t dr_wr;
  logic      dr_ack;
  logic      inj_req;
  inject_t   inj;
  logic      inj_ack;

  // reference model state and scoreboard
  logic [`DDC_DATA_WIDTH-1:0] model_addr;
  inject_t                    exp_q [$];
  bit                         wbbr_chk_q [$];
  int                         inj_open;
  int                         inj_count;
  int                         error_count;
  int                         cycle_cnt;

  ddc_top dut_i (
    .cpuclk  (cpuclk),
    .reset   (reset),
    .dr_req  (dr_req),
    .dr_wr   (dr_wr),
    .dr_ack  (dr_ack),
    .inj_req (inj_req),
    .inj     (inj),
    .inj_ack (inj_ack)
  );

  // 8 ns clock
  initial
  begin
    cpuclk = 1'b0;
    forever #4 cpuclk = ~cpuclk;
  end

  // ====================
  // timeout
  // ====================
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge cpuclk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the downloads did not finish", cycle_cnt);
    $display("Something failed");
    $finish;
  end

  // queue one predicted injection
  task automatic expect_inject(input logic [31:0] instr,
                               input logic [`DDC_DATA_WIDTH-1:0] wbbr,
                               input logic ffy, input bit chk_wbbr);
    inject_t p;
    begin
      p.instr = instr;
      p.wbbr  = wbbr;
      p.ffy   = ffy;
      exp_q.push_back(p);
      wbbr_chk_q.push_back(chk_wbbr);
    end
  endtask

  // four-phase write of one table row, updates the model on ack
  task automatic apply_write(input int idx);
    dr_write_t w;
    begin
      w.sel   = tbl_sel[idx];
      w.wdata = tbl_wdata[idx];
      dr_wr   = w;
      dr_req  = 1'b1;
      do
      begin
        @(posedge cpuclk);
        #1;
      end
      while (dr_ack !== 1'b1);
      // previous download must be closed, last inj_ack already low
      if (inj_open != 0)
      begin
        error_count++;
        $display("Write %0d got dr_ack at %0t with %0d injections still open",
                 idx, $time, inj_open);
      end
      if (w.sel == sel_daddr)
        model_addr = w.wdata;
      else
      begin
        if ((model_addr & pa_mask) != tbl_exp_pa[idx])
        begin
          error_count++;
          $display("Table row %0d expects address %h but the model holds %h",
                   idx, tbl_exp_pa[idx], model_addr & pa_mask);
        end
        expect_inject(inst_mv_x1, model_addr & pa_mask, 1'b1, 1'b1);
        expect_inject(inst_mv_x2, w.wdata, 1'b1, 1'b1);
        // store wbbr is a don't care
        expect_inject(inst_sd_x2_x1, '0, 1'b0, 1'b0);
        model_addr = model_addr + `DDC_DATA_WIDTH'(`DDC_ADDR_STEP);
        inj_open += 3;
      end
      dr_req = 1'b0;
      do
      begin
        @(posedge cpuclk);
        #1;
      end
      while (dr_ack !== 1'b0);
    end
  endtask

  // no ack and no injection for a few cycles
  task automatic check_no_activity(input int cycles);
    begin
      repeat (cycles)
      begin
        @(posedge cpuclk);
        #1;
        if ((inj_req !== 1'b0) || (dr_ack !== 1'b0))
        begin
          error_count++;
          $display("Activity at %0t with no data write pending, inj_req %b dr_ack %b",
                   $time, inj_req, dr_ack);
        end
      end
    end
  endtask

  // compare one injection with the oldest prediction
  task automatic check_packet(input inject_t got);
    inject_t exp;
    bit      chk_wbbr;
    begin
      if (exp_q.size() == 0)
      begin
        error_count++;
        $display("Injection at %0t with instr %h arrived with none expected",
                 $time, got.instr);
      end
      else
      begin
        exp      = exp_q.pop_front();
        chk_wbbr = wbbr_chk_q.pop_front();
        if ((got.instr !== exp.instr) || (got.ffy !== exp.ffy) ||
            (chk_wbbr && (got.wbbr !== exp.wbbr)))
        begin
          error_count++;
          $display("Mismatch at %0t: got instr %h wbbr %h ffy %b", $time,
                   got.instr, got.wbbr, got.ffy);
          $display("  expected instr %h wbbr %h ffy %b", exp.instr, exp.wbbr, exp.ffy);
        end
      end
    end
  endtask

  // inj must hold from req rise until ack fall
  task automatic check_inj_stable(input inject_t held);
    begin
      if (inj !== held)
      begin
        error_count++;
        $display("Mismatch at %0t: inj changed during handshake, now instr %h wbbr %h",
                 $time, inj.instr, inj.wbbr);
      end
    end
  endtask

  // ====================
  // core model
  // ====================
  initial
  begin
    inject_t held;
    int      delay;
    inj_ack = 1'b0;
    void'($urandom(seed));
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    forever
    begin
      @(posedge cpuclk);
      #1;
      if (inj_req === 1'b1)
      begin
        held = inj;
        inj_count++;
        check_packet(held);
        // 0 to 5 cycles before ack
        delay = $urandom % 6;
        repeat (delay)
        begin
          @(posedge cpuclk);
          #1;
          check_inj_stable(held);
        end
        inj_ack = 1'b1;
        do
        begin
          @(posedge cpuclk);
          #1;
          check_inj_stable(held);
        end
        while (inj_req === 1'b1);
        inj_ack = 1'b0;
        inj_open--;
      end
    end
  end

  // ====================
  // main sequence
  // ====================
  initial
  begin
    int i;
    reset       = 1'b1;
    dr_req      = 1'b0;
    dr_wr       = '0;
    model_addr  = '0;
    inj_open    = 0;
    inj_count   = 0;
    error_count = 0;
    repeat (2) @(posedge cpuclk);
    #1;
    reset = 1'b0;
    // quiet before the first request
    check_no_activity(4);
    for (i = 0; i < tbl_len; i++)
    begin
      apply_write(i);
      // an address write alone starts nothing
      if (tbl_sel[i] == sel_daddr)
        check_no_activity(4);
    end
    // drain the last download
    while (inj_open != 0)
    begin
      @(posedge cpuclk);
      #1;
    end
    check_no_activity(4);
    if (exp_q.size() != 0)
    begin
      error_count++;
      $display("%0d predicted injections never arrived", exp_q.size());
    end
    $display("Run done: %0d writes, %0d injections, %0d errors",
             tbl_len, inj_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* ddc.f */
+incdir+hw
hw/dbg_reg_pkg.sv
hw/ddc_inst_pkg.sv
hw/ddc_dr_port.sv
hw/ddc_ctrl.sv
hw/ddc_dp.sv
hw/ddc_inject_port.sv
hw/ddc_top.sv
bench/ddc_tb.sv

/* Makefile */
# Verilator build and run for the direct-download channel testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= ddc_tb
FILELIST  ?= ddc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
